/* hdl/lsu_defines.svh */
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// Queue entries, power of two
`define LSU_DEPTH 8

// ROB id width
`define LSU_ROB_W 5

// Physical and architectural register index widths
`define LSU_PHY_W 6
`define LSU_ARCH_W 5

// Data and address width
`define LSU_XLEN 32

`endif

/* hdl/lsu_pkg.sv */
`include "lsu_defines.svh"

package lsu_pkg;

    //////////////////////////////////////////////////
    // Memory operation encoding
    //////////////////////////////////////////////////

    // Bit 3 marks a store, bits 1:0 give the access size
    typedef enum logic [3:0] {
        MEM_LB  = 4'b0000,
        MEM_LH  = 4'b0001,
        MEM_LW  = 4'b0010,
        MEM_LBU = 4'b0100,
        MEM_LHU = 4'b0101,
        MEM_SB  = 4'b1000,
        MEM_SH  = 4'b1001,
        MEM_SW  = 4'b1010
    } mem_op_t;

    //////////////////////////////////////////////////
    // Queue entry
    //////////////////////////////////////////////////

    typedef struct packed {
        logic                     valid;
        // Address, mask and data have arrived from the AGU
        logic                     ready;
        mem_op_t                  op;
        logic [`LSU_ROB_W-1:0]    rob_id;
        logic [`LSU_PHY_W-1:0]    rd_phy;
        logic [`LSU_ARCH_W-1:0]   rd_arch;
        logic [`LSU_XLEN-1:0]     addr;
        logic [`LSU_XLEN/8-1:0]   mask;
        logic [`LSU_XLEN-1:0]     wdata;
    } lsq_entry_t;

endpackage

/* hdl/lsu_agu.sv */
`include "lsu_defines.svh"

module lsu_agu (
    input  logic                     clk,
    input  logic                     rst,

    input  logic                     iss_valid,
    input  logic [`LSU_ROB_W-1:0]    iss_rob_id,
    input  lsu_pkg::mem_op_t         iss_op,
    input  logic [`LSU_XLEN-1:0]     iss_base,
    input  logic [`LSU_XLEN-1:0]     iss_offset,
    input  logic [`LSU_XLEN-1:0]     iss_store_value,

    output logic                     agu_valid,
    output logic [`LSU_ROB_W-1:0]    agu_rob_id,
    output logic [`LSU_XLEN-1:0]     agu_addr,
    output logic [`LSU_XLEN/8-1:0]   agu_mask,
    output logic [`LSU_XLEN-1:0]     agu_wdata
);

    logic [`LSU_XLEN-1:0]     eff_addr;
    logic [`LSU_XLEN/8-1:0]   byte_mask;

    assign eff_addr = iss_base + iss_offset;

    // Size from the low op bits, accesses assumed aligned
    always_comb begin
        case (iss_op[1:0])
            2'b00:   byte_mask = 4'b0001 << eff_addr[1:0];
            2'b01:   byte_mask = 4'b0011 << {eff_addr[1], 1'b0};
            default: byte_mask = 4'b1111;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            agu_valid <= 1'b0;
        end else begin
            agu_valid <= iss_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (iss_valid) begin
            agu_rob_id <= iss_rob_id;
            agu_addr   <= eff_addr;
            agu_mask   <= byte_mask;
            // Move store data into its byte lane
            agu_wdata  <= iss_store_value << {eff_addr[1:0], 3'b000};
        end
    end

endmodule

/* hdl/lsu_queue.sv */
`include "lsu_defines.svh"

module lsu_queue (
    input  logic                     clk,
    input  logic                     rst,

    input  logic                     disp_valid,
    output logic                     disp_ready,
    input  lsu_pkg::mem_op_t         disp_op,
    input  logic [`LSU_ROB_W-1:0]    disp_rob_id,
    input  logic [`LSU_PHY_W-1:0]    disp_rd_phy,
    input  logic [`LSU_ARCH_W-1:0]   disp_rd_arch,

    input  logic                     agu_valid,
    input  logic [`LSU_ROB_W-1:0]    agu_rob_id,
    input  logic [`LSU_XLEN-1:0]     agu_addr,
    input  logic [`LSU_XLEN/8-1:0]   agu_mask,
    input  logic [`LSU_XLEN-1:0]     agu_wdata,

    output logic                     req_valid,
    output logic                     req_we,
    output logic [`LSU_XLEN-1:0]     req_addr,
    output logic [`LSU_XLEN/8-1:0]   req_sel,
    output logic [`LSU_XLEN-1:0]     req_wdata,
    input  logic                     done,
    input  logic [`LSU_XLEN-1:0]     rdata,

    output logic                     cdb_valid,
    output logic [`LSU_ROB_W-1:0]    cdb_rob_id,
    output logic [`LSU_PHY_W-1:0]    cdb_rd_phy,
    output logic [`LSU_ARCH_W-1:0]   cdb_rd_arch,
    output logic [`LSU_XLEN-1:0]     cdb_value,
    output logic                     cdb_is_store
);

    localparam int IDX_W = $clog2(`LSU_DEPTH);

    lsu_pkg::lsq_entry_t   entries [`LSU_DEPTH];
    lsu_pkg::lsq_entry_t   head;

    // Extra top bit is the wrap flag
    logic [IDX_W:0]        wr_ptr;
    logic [IDX_W:0]        rd_ptr;
    logic [IDX_W-1:0]      wr_idx;
    logic [IDX_W-1:0]      rd_idx;
    logic                  full;
    logic                  empty;
    logic                  enqueue;
    logic                  dequeue;
    logic [7:0]            load_byte;
    logic [15:0]           load_half;

    //////////////////////////////////////////////////
    // Pointers
    //////////////////////////////////////////////////

    assign wr_idx     = wr_ptr[IDX_W-1:0];
    assign rd_idx     = rd_ptr[IDX_W-1:0];
    assign empty      = (wr_ptr == rd_ptr);
    assign full       = (wr_idx == rd_idx) && (wr_ptr[IDX_W] != rd_ptr[IDX_W]);
    assign disp_ready = !full;
    assign enqueue    = disp_valid && disp_ready;
    assign dequeue    = done;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (enqueue) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (dequeue) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // Entry updates
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `LSU_DEPTH; i++) begin
                entries[i].valid <= 1'b0;
                entries[i].ready <= 1'b0;
            end
        end else begin
            // ROB ids are unique among live entries
            if (agu_valid) begin
                for (int i = 0; i < `LSU_DEPTH; i++) begin
                    if (entries[i].valid && entries[i].rob_id == agu_rob_id) begin
                        entries[i].ready <= 1'b1;
                        entries[i].addr  <= agu_addr;
                        entries[i].mask  <= agu_mask;
                        entries[i].wdata <= agu_wdata;
                    end
                end
            end
            if (dequeue) begin
                entries[rd_idx].valid <= 1'b0;
            end
            if (enqueue) begin
                entries[wr_idx].valid   <= 1'b1;
                entries[wr_idx].ready   <= 1'b0;
                entries[wr_idx].op      <= disp_op;
                entries[wr_idx].rob_id  <= disp_rob_id;
                entries[wr_idx].rd_phy  <= disp_rd_phy;
                entries[wr_idx].rd_arch <= disp_rd_arch;
            end
        end
    end

    //////////////////////////////////////////////////
    // Head request and result
    //////////////////////////////////////////////////

    assign head      = entries[rd_idx];
    assign req_valid = !empty && head.valid && head.ready;
    assign req_we    = head.op[3];
    assign req_addr  = {head.addr[`LSU_XLEN-1:2], 2'b00};
    assign req_sel   = head.mask;
    assign req_wdata = head.wdata;

    assign load_byte = rdata[{head.addr[1:0], 3'b000} +: 8];
    assign load_half = rdata[{head.addr[1], 4'b0000} +: 16];

    always_comb begin
        case (head.op)
            lsu_pkg::MEM_LB:  cdb_value = {{24{load_byte[7]}}, load_byte};
            lsu_pkg::MEM_LBU: cdb_value = {24'b0, load_byte};
            lsu_pkg::MEM_LH:  cdb_value = {{16{load_half[15]}}, load_half};
            lsu_pkg::MEM_LHU: cdb_value = {16'b0, load_half};
            lsu_pkg::MEM_LW:  cdb_value = rdata;
            // Stores report zero
            default:          cdb_value = '0;
        endcase
    end

    assign cdb_valid    = done;
    assign cdb_rob_id   = head.rob_id;
    assign cdb_rd_phy   = head.rd_phy;
    assign cdb_rd_arch  = head.rd_arch;
    assign cdb_is_store = head.op[3];

endmodule

/* hdl/lsu_wb_master.sv */
`include "lsu_defines.svh"

module lsu_wb_master (
    input  logic                     clk,
    input  logic                     rst,

    input  logic                     req_valid,
    input  logic                     req_we,
    input  logic [`LSU_XLEN-1:0]     req_addr,
    input  logic [`LSU_XLEN/8-1:0]   req_sel,
    input  logic [`LSU_XLEN-1:0]     req_wdata,
    output logic                     done,
    output logic [`LSU_XLEN-1:0]     rdata,

    output logic                     wb_cyc,
    output logic                     wb_stb,
    output logic                     wb_we,
    output logic [`LSU_XLEN-1:0]     wb_adr,
    output logic [`LSU_XLEN/8-1:0]   wb_sel,
    output logic [`LSU_XLEN-1:0]     wb_wdata,
    input  logic [`LSU_XLEN-1:0]     wb_rdata,
    input  logic                     wb_ack
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BUS,
        ST_RESP
    } state_t;

    state_t state;

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= ST_IDLE;
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            done   <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (req_valid) begin
                        wb_cyc <= 1'b1;
                        wb_stb <= 1'b1;
                        state  <= ST_BUS;
                    end
                end
                ST_BUS: begin
                    if (wb_ack) begin
                        wb_cyc <= 1'b0;
                        wb_stb <= 1'b0;
                        done   <= 1'b1;
                        state  <= ST_RESP;
                    end
                end
                // Queue retires its head here, new head seen in idle
                ST_RESP: state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Bus fields held from the latch until ack
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && req_valid) begin
            wb_we    <= req_we;
            wb_adr   <= req_addr;
            wb_sel   <= req_sel;
            wb_wdata <= req_wdata;
        end
        if (state == ST_BUS && wb_ack) begin
            rdata <= wb_rdata;
        end
    end

endmodule

/* hdl/lsu_top.sv */
`include "lsu_defines.svh"

module lsu_top (
    input  logic                     clk,
    input  logic                     rst,

    input  logic                     disp_valid,
    output logic                     disp_ready,
    input  lsu_pkg::mem_op_t         disp_op,
    input  logic [`LSU_ROB_W-1:0]    disp_rob_id,
    input  logic [`LSU_PHY_W-1:0]    disp_rd_phy,
    input  logic [`LSU_ARCH_W-1:0]   disp_rd_arch,

    input  logic                     iss_valid,
    input  logic [`LSU_ROB_W-1:0]    iss_rob_id,
    input  lsu_pkg::mem_op_t         iss_op,
    input  logic [`LSU_XLEN-1:0]     iss_base,
    input  logic [`LSU_XLEN-1:0]     iss_offset,
    input  logic [`LSU_XLEN-1:0]     iss_store_value,

    output logic                     wb_cyc,
    output logic                     wb_stb,
    output logic                     wb_we,
    output logic [`LSU_XLEN-1:0]     wb_adr,
    output logic [`LSU_XLEN/8-1:0]   wb_sel,
    output logic [`LSU_XLEN-1:0]     wb_wdata,
    input  logic [`LSU_XLEN-1:0]     wb_rdata,
    input  logic                     wb_ack,

    output logic                     cdb_valid,
    output logic [`LSU_ROB_W-1:0]    cdb_rob_id,
    output logic [`LSU_PHY_W-1:0]    cdb_rd_phy,
    output logic [`LSU_ARCH_W-1:0]   cdb_rd_arch,
    output logic [`LSU_XLEN-1:0]     cdb_value,
    output logic                     cdb_is_store
);

    logic                     agu_valid;
    logic [`LSU_ROB_W-1:0]    agu_rob_id;
    logic [`LSU_XLEN-1:0]     agu_addr;
    logic [`LSU_XLEN/8-1:0]   agu_mask;
    logic [`LSU_XLEN-1:0]     agu_wdata;
    logic                     req_valid;
    logic                     req_we;
    logic [`LSU_XLEN-1:0]     req_addr;
    logic [`LSU_XLEN/8-1:0]   req_sel;
    logic [`LSU_XLEN-1:0]     req_wdata;
    logic                     done;
    logic [`LSU_XLEN-1:0]     rdata;

    lsu_agu lsu_agu_inst (
        .clk, .rst,
        .iss_valid, .iss_rob_id, .iss_op, .iss_base, .iss_offset, .iss_store_value,
        .agu_valid, .agu_rob_id, .agu_addr, .agu_mask, .agu_wdata
    );

    lsu_queue lsu_queue_inst (
        .clk, .rst,
        .disp_valid, .disp_ready, .disp_op, .disp_rob_id, .disp_rd_phy, .disp_rd_arch,
        .agu_valid, .agu_rob_id, .agu_addr, .agu_mask, .agu_wdata,
        .req_valid, .req_we, .req_addr, .req_sel, .req_wdata, .done, .rdata,
        .cdb_valid, .cdb_rob_id, .cdb_rd_phy, .cdb_rd_arch, .cdb_value, .cdb_is_store
    );

    lsu_wb_master lsu_wb_master_inst (
        .clk, .rst,
        .req_valid, .req_we, .req_addr, .req_sel, .req_wdata, .done, .rdata,
        .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_sel, .wb_wdata, .wb_rdata, .wb_ack
    );

endmodule

/* verification/tb_clock_gen.sv */
module tb_clock_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // High for three rising edges, released on a falling edge
    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

/* verification/wb_mem_model.sv */
`include "lsu_defines.svh"

module wb_mem_model #(
    parameter int SEED = 1
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     wb_cyc,
    input  logic                     wb_stb,
    input  logic                     wb_we,
    input  logic [`LSU_XLEN-1:0]     wb_adr,
    input  logic [`LSU_XLEN/8-1:0]   wb_sel,
    input  logic [`LSU_XLEN-1:0]     wb_wdata,
    output logic [`LSU_XLEN-1:0]     wb_rdata,
    output logic                     wb_ack
);

    localparam int WORDS = 256;

    logic [`LSU_XLEN-1:0]   mem [WORDS];
    logic [7:0]             word_idx;
    logic                   busy;
    logic [1:0]             wait_cnt;
    logic [31:0]            rnd;
    int                     seed;

    assign word_idx = wb_adr[9:2];

    initial begin
        seed = SEED;
        for (int i = 0; i < WORDS; i++) begin
            mem[i] = $random(seed);
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            wb_ack   <= 1'b0;
            wb_rdata <= '0;
            busy     <= 1'b0;
            wait_cnt <= 2'd0;
        end else begin
            wb_ack <= 1'b0;
            if (wb_cyc && wb_stb && !busy && !wb_ack) begin
                // Ack comes one to three cycles later
                rnd = $random(seed);
                wait_cnt <= 2'(rnd % 32'd3);
                busy     <= 1'b1;
            end else if (busy) begin
                if (wait_cnt == 2'd0) begin
                    busy   <= 1'b0;
                    wb_ack <= 1'b1;
                    if (wb_we) begin
                        for (int b = 0; b < `LSU_XLEN / 8; b++) begin
                            if (wb_sel[b]) begin
                                mem[word_idx][8*b +: 8] = wb_wdata[8*b +: 8];
                            end
                        end
                    end else begin
                        wb_rdata <= mem[word_idx];
                    end
                end else begin
                    wait_cnt <= wait_cnt - 1'b1;
                end
            end
        end
    end

endmodule

/* verification/lsu_tb.sv */
`include "lsu_defines.svh"

module lsu_tb;

    localparam int SEED           = 37323;
    localparam int MEM_WORDS      = 256;
    // About 110 memory ops at under ten cycles each, four times over
    localparam int TIMEOUT_CYCLES = 4000;

    typedef struct packed {
        logic [`LSU_ROB_W-1:0]    rob_id;
        logic [`LSU_PHY_W-1:0]    rd_phy;
        logic [`LSU_ARCH_W-1:0]   rd_arch;
        logic [`LSU_XLEN-1:0]     value;
        logic                     is_store;
    } result_t;

    logic                     clk;
    logic                     rst;
    logic                     disp_valid;
    logic                     disp_ready;
    lsu_pkg::mem_op_t         disp_op;
    logic [`LSU_ROB_W-1:0]    disp_rob_id;
    logic [`LSU_PHY_W-1:0]    disp_rd_phy;
    logic [`LSU_ARCH_W-1:0]   disp_rd_arch;
    logic                     iss_valid;
    logic [`LSU_ROB_W-1:0]    iss_rob_id;
    lsu_pkg::mem_op_t         iss_op;
    logic [`LSU_XLEN-1:0]     iss_base;
    logic [`LSU_XLEN-1:0]     iss_offset;
    logic [`LSU_XLEN-1:0]     iss_store_value;
    logic                     wb_cyc;
    logic                     wb_stb;
    logic                     wb_we;
    logic [`LSU_XLEN-1:0]     wb_adr;
    logic [`LSU_XLEN/8-1:0]   wb_sel;
    logic [`LSU_XLEN-1:0]     wb_wdata;
    logic [`LSU_XLEN-1:0]     wb_rdata;
    logic                     wb_ack;
    logic                     cdb_valid;
    logic [`LSU_ROB_W-1:0]    cdb_rob_id;
    logic [`LSU_PHY_W-1:0]    cdb_rd_phy;
    logic [`LSU_ARCH_W-1:0]   cdb_rd_arch;
    logic [`LSU_XLEN-1:0]     cdb_value;
    logic                     cdb_is_store;

    logic [`LSU_XLEN-1:0]     shadow [MEM_WORDS];
    result_t                  expected [$];
    result_t                  exp_res;

    // Batch in program order
    lsu_pkg::mem_op_t         b_op [`LSU_DEPTH];
    logic [`LSU_ROB_W-1:0]    b_rob [`LSU_DEPTH];
    logic [`LSU_PHY_W-1:0]    b_phy [`LSU_DEPTH];
    logic [`LSU_ARCH_W-1:0]   b_arch [`LSU_DEPTH];
    logic [`LSU_XLEN-1:0]     b_addr [`LSU_DEPTH];
    logic [`LSU_XLEN-1:0]     b_value [`LSU_DEPTH];
    int                       b_len = 0;
    logic [`LSU_ROB_W-1:0]    next_rob = '0;

    logic                     bus_open = 1'b0;
    logic                     held_we;
    logic [`LSU_XLEN-1:0]     held_adr;
    logic [`LSU_XLEN/8-1:0]   held_sel;
    logic [`LSU_XLEN-1:0]     held_wdata;

    int                       seed;
    int                       errors = 0;
    int                       results = 0;
    int                       bus_cycles = 0;
    int                       cycle_count = 0;
    int                       seen;

    tb_clock_gen clock_gen_inst (
        .clk, .rst
    );

    lsu_top lsu_top_inst (
        .clk, .rst,
        .disp_valid, .disp_ready, .disp_op, .disp_rob_id, .disp_rd_phy, .disp_rd_arch,
        .iss_valid, .iss_rob_id, .iss_op, .iss_base, .iss_offset, .iss_store_value,
        .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_sel, .wb_wdata, .wb_rdata, .wb_ack,
        .cdb_valid, .cdb_rob_id, .cdb_rd_phy, .cdb_rd_arch, .cdb_value, .cdb_is_store
    );

    wb_mem_model #(.SEED(SEED)) wb_mem_inst (
        .clk, .rst,
        .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_sel, .wb_wdata, .wb_rdata, .wb_ack
    );

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    task automatic report_mismatch(input string msg);
        $display("[FAIL] %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic print_counts();
        $display("Results %0d, bus cycles %0d, errors %0d", results, bus_cycles, errors);
    endtask

    function automatic logic [31:0] lane_value(input lsu_pkg::mem_op_t op,
                                               input logic [31:0] word,
                                               input logic [1:0] lane);
        logic [7:0]  byte_val;
        logic [15:0] half_val;
        byte_val = 8'(word >> (8 * lane));
        half_val = 16'(word >> (8 * lane));
        case (op)
            lsu_pkg::MEM_LB:  return {{24{byte_val[7]}}, byte_val};
            lsu_pkg::MEM_LBU: return {24'h0, byte_val};
            lsu_pkg::MEM_LH:  return {{16{half_val[15]}}, half_val};
            lsu_pkg::MEM_LHU: return {16'h0, half_val};
            lsu_pkg::MEM_LW:  return word;
            default:          return 32'h0;
        endcase
    endfunction

    // Low bytes of the store value land from the lane upward
    function automatic logic [31:0] merge_store(input lsu_pkg::mem_op_t op,
                                                input logic [31:0] word,
                                                input logic [1:0] lane,
                                                input logic [31:0] value);
        logic [31:0] merged;
        int          size;
        merged = word;
        size = (op == lsu_pkg::MEM_SB) ? 1 : (op == lsu_pkg::MEM_SH) ? 2 : 4;
        for (int i = 0; i < size; i++) begin
            merged[8*(lane+i) +: 8] = value[8*i +: 8];
        end
        return merged;
    endfunction

    function automatic lsu_pkg::mem_op_t pick_op(input logic [2:0] sel);
        case (sel)
            3'd0:    return lsu_pkg::MEM_LB;
            3'd1:    return lsu_pkg::MEM_LH;
            3'd2:    return lsu_pkg::MEM_LW;
            3'd3:    return lsu_pkg::MEM_LBU;
            3'd4:    return lsu_pkg::MEM_LHU;
            3'd5:    return lsu_pkg::MEM_SB;
            3'd6:    return lsu_pkg::MEM_SH;
            default: return lsu_pkg::MEM_SW;
        endcase
    endfunction

    function automatic logic [1:0] aligned_lane(input lsu_pkg::mem_op_t op,
                                                input logic [1:0] r);
        if (op == lsu_pkg::MEM_LB || op == lsu_pkg::MEM_LBU || op == lsu_pkg::MEM_SB) begin
            return r;
        end
        if (op == lsu_pkg::MEM_LH || op == lsu_pkg::MEM_LHU || op == lsu_pkg::MEM_SH) begin
            return {r[1], 1'b0};
        end
        return 2'b00;
    endfunction

    task automatic add_op(input lsu_pkg::mem_op_t op, input logic [7:0] word_idx,
                          input logic [1:0] lane);
        result_t res;
        res.rob_id   = next_rob;
        res.rd_phy   = 6'($random(seed));
        res.rd_arch  = 5'($random(seed));
        res.is_store = op[3];
        b_op[b_len]    = op;
        b_rob[b_len]   = next_rob;
        b_phy[b_len]   = res.rd_phy;
        b_arch[b_len]  = res.rd_arch;
        b_addr[b_len]  = {22'b0, word_idx, lane};
        b_value[b_len] = $random(seed);
        if (op[3]) begin
            res.value = 32'h0;
            shadow[word_idx] = merge_store(op, shadow[word_idx], lane, b_value[b_len]);
        end else begin
            res.value = lane_value(op, shadow[word_idx], lane);
        end
        expected.push_back(res);
        next_rob = next_rob + 1'b1;
        b_len++;
    endtask

    task automatic add_random_op();
        logic [31:0]      r;
        lsu_pkg::mem_op_t op;
        r = $random(seed);
        op = pick_op(r[2:0]);
        // Eight shared words, so stores and loads overlap
        add_op(op, {5'b10100, r[5:3]}, aligned_lane(op, r[7:6]));
    endtask

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    task automatic dispatch_batch();
        for (int k = 0; k < b_len; k++) begin
            while (!disp_ready) begin
                @(negedge clk);
            end
            disp_valid   = 1'b1;
            disp_op      = b_op[k];
            disp_rob_id  = b_rob[k];
            disp_rd_phy  = b_phy[k];
            disp_rd_arch = b_arch[k];
            @(negedge clk);
        end
        disp_valid = 1'b0;
    endtask

    task automatic issue_batch(input logic reverse);
        int          order [`LSU_DEPTH];
        int          j;
        int          tmp;
        int          idx;
        logic [31:0] r;
        logic [31:0] off;
        for (int i = 0; i < b_len; i++) begin
            order[i] = reverse ? b_len - 1 - i : i;
        end
        if (!reverse) begin
            for (int i = b_len - 1; i > 0; i--) begin
                r = $random(seed);
                j = int'(r % 32'(i + 1));
                tmp = order[i];
                order[i] = order[j];
                order[j] = tmp;
            end
        end
        for (int k = 0; k < b_len; k++) begin
            idx = order[k];
            r = $random(seed);
            off = {{26{r[5]}}, r[5:0]};
            iss_valid       = 1'b1;
            iss_rob_id      = b_rob[idx];
            iss_op          = b_op[idx];
            iss_offset      = off;
            iss_base        = b_addr[idx] - off;
            iss_store_value = b_value[idx];
            @(negedge clk);
        end
        iss_valid = 1'b0;
    endtask

    task automatic drain();
        while (expected.size() != 0) begin
            @(negedge clk);
        end
        b_len = 0;
    endtask

    task automatic run_batch(input logic reverse);
        dispatch_batch();
        issue_batch(reverse);
        drain();
    endtask

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    assert property (@(posedge clk) disable iff (rst) wb_stb |-> wb_cyc)
        else report_mismatch("wb_stb high without wb_cyc");
    assert property (@(posedge clk) disable iff (rst) wb_cyc |-> (wb_adr[1:0] == 2'b00))
        else report_mismatch("wb_adr not word aligned");
    // One result per acked bus cycle
    assert property (@(posedge clk) disable iff (rst) cdb_valid == $past(wb_ack))
        else report_mismatch("cdb_valid does not follow wb_ack by one cycle");

    always @(posedge clk) begin
        if (!rst && wb_stb) begin
            if (bus_open) begin
                assert (wb_adr == held_adr && wb_sel == held_sel && wb_we == held_we &&
                        wb_wdata == held_wdata)
                    else report_mismatch("Wishbone fields changed before ack");
            end else begin
                held_adr   = wb_adr;
                held_sel   = wb_sel;
                held_we    = wb_we;
                held_wdata = wb_wdata;
            end
            bus_open = !wb_ack;
            if (wb_ack) begin
                bus_cycles++;
            end
        end
    end

    always @(posedge clk) begin
        if (!rst && cdb_valid) begin
            if (expected.size() == 0) begin
                $display("Result for ROB id %0d arrived with nothing pending", cdb_rob_id);
                errors++;
            end else begin
                exp_res = expected.pop_front();
                assert (cdb_rob_id == exp_res.rob_id)
                    else report_mismatch($sformatf("cdb_rob_id %0d, expected %0d",
                                                   cdb_rob_id, exp_res.rob_id));
                assert (cdb_rd_phy == exp_res.rd_phy && cdb_rd_arch == exp_res.rd_arch)
                    else report_mismatch($sformatf("rd of ROB id %0d wrong", cdb_rob_id));
                assert (cdb_is_store == exp_res.is_store)
                    else report_mismatch($sformatf("cdb_is_store wrong, ROB id %0d", cdb_rob_id));
                assert (cdb_value == exp_res.value)
                    else report_mismatch($sformatf("cdb_value %h, expected %h, ROB id %0d",
                                                   cdb_value, exp_res.value, cdb_rob_id));
            end
            results++;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the tests did not complete", cycle_count);
            print_counts();
            $display("RESULT: FAIL");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////

    initial begin
        disp_valid      = 1'b0;
        disp_op         = lsu_pkg::MEM_LW;
        disp_rob_id     = '0;
        disp_rd_phy     = '0;
        disp_rd_arch    = '0;
        iss_valid       = 1'b0;
        iss_rob_id      = '0;
        iss_op          = lsu_pkg::MEM_LW;
        iss_base        = '0;
        iss_offset      = '0;
        iss_store_value = '0;

        // Same sequence the memory model preloads with
        seed = SEED;
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[i] = $random(seed);
        end

        @(posedge clk);
        while (rst) begin
            @(posedge clk);
        end
        @(negedge clk);
        assert (!wb_cyc && !wb_stb && !cdb_valid && disp_ready)
            else report_mismatch("outputs not in reset state after reset");

        // Every load kind at every lane
        for (int k = 0; k < 4; k++) begin
            add_op(lsu_pkg::MEM_LB, 8'($random(seed)), 2'(k));
            add_op(lsu_pkg::MEM_LBU, 8'($random(seed)), 2'(k));
        end
        run_batch(1'b0);
        for (int k = 0; k < 2; k++) begin
            add_op(lsu_pkg::MEM_LH, 8'($random(seed)), 2'(2 * k));
            add_op(lsu_pkg::MEM_LHU, 8'($random(seed)), 2'(2 * k));
        end
        add_op(lsu_pkg::MEM_LW, 8'($random(seed)), 2'd0);
        run_batch(1'b0);

        // Store then load of the same word, issued in reverse
        add_op(lsu_pkg::MEM_SB, 8'h30, 2'd1);
        add_op(lsu_pkg::MEM_LW, 8'h30, 2'd0);
        add_op(lsu_pkg::MEM_SH, 8'h31, 2'd2);
        add_op(lsu_pkg::MEM_LW, 8'h31, 2'd0);
        add_op(lsu_pkg::MEM_SW, 8'h32, 2'd0);
        add_op(lsu_pkg::MEM_LW, 8'h32, 2'd0);
        add_op(lsu_pkg::MEM_SB, 8'h30, 2'd3);
        add_op(lsu_pkg::MEM_LH, 8'h30, 2'd2);
        run_batch(1'b1);

        // Full queue with nothing issued
        for (int k = 0; k < `LSU_DEPTH; k++) begin
            add_op(lsu_pkg::MEM_LW, 8'(k * 3), 2'd0);
        end
        for (int k = 0; k < b_len; k++) begin
            assert (disp_ready) else report_mismatch("disp_ready low before queue full");
            disp_valid   = 1'b1;
            disp_op      = b_op[k];
            disp_rob_id  = b_rob[k];
            disp_rd_phy  = b_phy[k];
            disp_rd_arch = b_arch[k];
            @(negedge clk);
        end
        disp_valid = 1'b0;
        repeat (3) @(negedge clk);
        seen = results;
        // Head goes last, so no result can come during issue
        issue_batch(1'b1);
        while (results == seen) begin
            assert (!disp_ready) else report_mismatch("disp_ready high with a full queue");
            @(negedge clk);
        end
        assert (disp_ready) else report_mismatch("disp_ready still low after a result");
        drain();

        for (int n = 0; n < 10; n++) begin
            for (int k = 0; k < `LSU_DEPTH; k++) begin
                add_random_op();
            end
            run_batch(n == 4);
        end

        repeat (4) @(negedge clk);
        assert (results == bus_cycles)
            else report_mismatch($sformatf("%0d results for %0d bus cycles", results, bus_cycles));
        print_counts();
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* all.f */
+incdir+hdl
hdl/lsu_pkg.sv
hdl/lsu_agu.sv
hdl/lsu_queue.sv
hdl/lsu_wb_master.sv
hdl/lsu_top.sv
verification/tb_clock_gen.sv
verification/wb_mem_model.sv
verification/lsu_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the LSU testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module lsu_tb -Mdir "$BUILD_DIR" -f all.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/Vlsu_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "RESULT: FAIL" "$LOG"; then
    exit 1
fi
exit 0
